//--- files.f
source/axi_lite_pkg.sv
source/reg_map_pkg.sv
source/reg_access_if.sv
source/axi_lite_slave.sv
source/reg_file.sv
source/uart_reg_block.sv
tests/reg_block_checker.sv
tests/tb_uart_reg_block.sv

//--- source/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [STRB_W-1:0] axi_strb_t;  // One bit per byte lane
    typedef logic [RESP_W-1:0] axi_resp_t;

    // Response codes
    // EXOKAY and DECERR are never returned by this block
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- source/axi_lite_slave.sv
`timescale 1ns/100ps
`default_nettype none

module axi_lite_slave import axi_lite_pkg::*, reg_map_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,

    // Write address channel
    input  wire logic      awvalid,
    input  wire axi_addr_t awaddr,
    output logic           awready,

    // Write data channel
    input  wire logic      wvalid,
    input  wire axi_data_t wdata,
    input  wire axi_strb_t wstrb,
    output logic           wready,

    // Write response channel
    output logic           bvalid,
    input  wire logic      bready,
    output axi_resp_t      bresp,

    // Read address channel
    input  wire logic      arvalid,
    input  wire axi_addr_t araddr,
    output logic           arready,

    // Read data channel
    output logic           rvalid,
    input  wire logic      rready,
    output axi_data_t      rdata,
    output axi_resp_t      rresp,

    input  wire err_code_t error_code,  // Bridge error sampled at AW acceptance
    reg_access_if.bus      acc
);

    bus_state_t  state;
    bus_state_t  state_nxt;
    reg_offset_t wr_offset;
    reg_offset_t rd_offset;
    logic        wr_crc;     // CRC error seen when the write address was taken
    axi_resp_t   bresp_q;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;

    assign awready = (state == IDLE);
    assign arready = (state == IDLE) && !awvalid;  // A write wins over a read
    assign wready  = (state == WRITE_DATA);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_nxt = WRITE_DATA;
                end else if (ar_hs) begin
                    state_nxt = READ_DATA;
                end
            end
            WRITE_DATA: begin
                if (w_hs) begin
                    state_nxt = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    state_nxt = IDLE;
                end
            end
            READ_DATA: begin
                if (rready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Address capture and write response
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_offset <= awaddr[11:0];
            wr_crc    <= (error_code == ERR_CRC);
        end
        if (ar_hs) begin
            rd_offset <= araddr[11:0];
        end
        if (w_hs) begin
            bresp_q <= (acc.wr_bad || wr_crc) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Register file access
    assign acc.wr_en = w_hs;
    assign acc.addr  = (state == READ_DATA) ? rd_offset : wr_offset;
    assign acc.wdata = wdata;
    assign acc.wstrb = wstrb;

    assign bvalid = (state == WRITE_RESP);
    assign bresp  = bresp_q;
    assign rvalid = (state == READ_DATA);
    assign rdata  = acc.rdata;  // Decoder already zeroes illegal reads
    assign rresp  = acc.rd_bad ? RESP_SLVERR : RESP_OKAY;

    // Held read response keeps its data
    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    // Illegal reads return zero data
    assert property (@(posedge clk) disable iff (rst) rvalid && acc.rd_bad |-> rdata == '0);

endmodule

`default_nettype wire

//--- source/reg_access_if.sv
`timescale 1ns/100ps
`default_nettype none

interface reg_access_if import axi_lite_pkg::*, reg_map_pkg::*;;

    logic        wr_en;   // Single-cycle write command
    reg_offset_t addr;    // Write offset, or read offset during a read
    axi_data_t   wdata;
    axi_strb_t   wstrb;
    axi_data_t   rdata;   // Combinational read word for addr
    logic        wr_bad;  // Write at addr with wstrb is illegal
    logic        rd_bad;  // Read at addr is illegal

    // Bus engine side
    modport bus (
        output wr_en,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  wr_bad,
        input  rd_bad
    );

    // Register file side
    modport regs (
        input  wr_en,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output wr_bad,
        output rd_bad
    );

endinterface

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import axi_lite_pkg::*, reg_map_pkg::*; #(
    parameter baud_div_t config_reset = CONFIG_RESET_DEFAULT
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       soft_reset,  // One-cycle pulse, config survives it
    reg_access_if.regs      acc,

    // Status from the bridge
    input  wire logic       busy,
    input  wire err_code_t  error_code,
    input  wire count_t     tx_count,
    input  wire count_t     rx_count,
    input  wire fifo_stat_t fifo_status,

    // Configuration to the bridge
    output logic            reset_stats,
    output baud_div_t       baud_div,
    output timeout_t        timeout,
    output debug_mode_t     debug_mode
);

    logic        ctrl_en;       // Control bit 0
    baud_div_t   config_reg;
    debug_mode_t debug_reg;
    axi_data_t   test_reg [4];

    reg_offset_t aligned;
    logic [1:0]  test_idx;
    axi_data_t   cur_word;      // Current value of the addressed writable register
    axi_data_t   merged;
    logic        wr_ok;

    function automatic logic is_mapped(reg_offset_t off);
        case (off)
            OFF_CONTROL, OFF_STATUS, OFF_CONFIG, OFF_DEBUG,
            OFF_TX_COUNT, OFF_RX_COUNT, OFF_FIFO_STAT, OFF_VERSION,
            OFF_TEST_0, OFF_TEST_1, OFF_TEST_2, OFF_TEST_3: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Byte, low half, upper half and full word only
    function automatic logic strobe_ok(logic [1:0] lsb, axi_strb_t strb);
        case (strb)
            4'b0001, 4'b0011, 4'b1111: return (lsb == 2'b00);
            4'b1100:                   return (lsb == 2'b10);
            default:                   return 1'b0;
        endcase
    endfunction

    function automatic axi_data_t merge_bytes(axi_data_t cur, axi_data_t wd, axi_strb_t strb);
        axi_data_t res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = wd[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign aligned  = {acc.addr[11:2], 2'b00};
    assign test_idx = aligned[3:2];

    // Legality
    assign acc.wr_bad = !(is_mapped(aligned) && strobe_ok(acc.addr[1:0], acc.wstrb));
    assign acc.rd_bad = !is_mapped(aligned) || (acc.addr[1:0] != 2'b00);

    assign wr_ok = acc.wr_en && !acc.wr_bad;

    always_comb begin
        cur_word = '0;
        case (aligned)
            OFF_CONTROL: cur_word = axi_data_t'(ctrl_en);
            OFF_CONFIG:  cur_word = axi_data_t'(config_reg);
            OFF_DEBUG:   cur_word = axi_data_t'(debug_reg);
            OFF_TEST_0, OFF_TEST_1, OFF_TEST_2, OFF_TEST_3: begin
                cur_word = test_reg[test_idx];
            end
            default: cur_word = '0;  // RO views take no writes
        endcase
    end

    assign merged = merge_bytes(cur_word, acc.wdata, acc.wstrb);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_en    <= 1'b0;
            config_reg <= config_reset;
            debug_reg  <= '0;
            test_reg   <= '{default: '0};
        end else if (soft_reset) begin
            // Baud setting is kept so the link stays up
            ctrl_en   <= 1'b0;
            debug_reg <= '0;
            test_reg  <= '{default: '0};
        end else if (wr_ok) begin
            case (aligned)
                OFF_CONTROL: ctrl_en    <= merged[0];
                OFF_CONFIG:  config_reg <= merged[15:0];
                OFF_DEBUG:   debug_reg  <= merged[3:0];
                OFF_TEST_0, OFF_TEST_1, OFF_TEST_2, OFF_TEST_3: begin
                    test_reg[test_idx] <= merged;
                end
                default: ;
            endcase
        end
    end

    // Bit 1 of control is a self-clearing statistics reset
    always_ff @(posedge clk) begin
        if (rst) begin
            reset_stats <= 1'b0;
        end else begin
            reset_stats <= wr_ok && !soft_reset && (aligned == OFF_CONTROL)
                           && acc.wstrb[0] && acc.wdata[1];
        end
    end

    // Read multiplexer
    always_comb begin
        acc.rdata = '0;
        if (!acc.rd_bad) begin
            case (aligned)
                OFF_CONTROL:   acc.rdata = axi_data_t'(ctrl_en);
                OFF_STATUS:    acc.rdata = axi_data_t'({error_code, busy});
                OFF_CONFIG:    acc.rdata = axi_data_t'(config_reg);
                OFF_DEBUG:     acc.rdata = axi_data_t'(debug_reg);
                OFF_TX_COUNT:  acc.rdata = axi_data_t'(tx_count);
                OFF_RX_COUNT:  acc.rdata = axi_data_t'(rx_count);
                OFF_FIFO_STAT: acc.rdata = axi_data_t'(fifo_status);
                OFF_VERSION:   acc.rdata = VERSION_WORD;
                OFF_TEST_0, OFF_TEST_1, OFF_TEST_2, OFF_TEST_3: begin
                    acc.rdata = test_reg[test_idx];
                end
                default: acc.rdata = '0;
            endcase
        end
    end

    assign baud_div   = config_reg;
    assign timeout    = config_reg[15:8];  // Shares the divisor's upper byte
    assign debug_mode = debug_reg;

    assert property (@(posedge clk) disable iff (rst) reset_stats |=> !reset_stats);

endmodule

`default_nettype wire

//--- source/reg_map_pkg.sv
`default_nettype none

package reg_map_pkg;

    // Byte offset inside the block, only the low 12 address bits decode
    typedef logic [11:0] reg_offset_t;

    localparam reg_offset_t OFF_CONTROL   = 12'h000;
    localparam reg_offset_t OFF_STATUS    = 12'h004;  // RO
    localparam reg_offset_t OFF_CONFIG    = 12'h008;
    localparam reg_offset_t OFF_DEBUG     = 12'h00C;
    localparam reg_offset_t OFF_TX_COUNT  = 12'h010;  // RO
    localparam reg_offset_t OFF_RX_COUNT  = 12'h014;  // RO
    localparam reg_offset_t OFF_FIFO_STAT = 12'h018;  // RO
    localparam reg_offset_t OFF_VERSION   = 12'h01C;  // RO
    localparam reg_offset_t OFF_TEST_0    = 12'h020;
    localparam reg_offset_t OFF_TEST_1    = 12'h024;
    localparam reg_offset_t OFF_TEST_2    = 12'h028;
    localparam reg_offset_t OFF_TEST_3    = 12'h02C;

    // Field widths
    typedef logic [15:0] baud_div_t;
    typedef logic [7:0]  timeout_t;
    typedef logic [3:0]  debug_mode_t;
    typedef logic [7:0]  err_code_t;
    typedef logic [15:0] count_t;
    typedef logic [7:0]  fifo_stat_t;

    // Bridge error code that turns a legal write response into SLVERR
    localparam err_code_t ERR_CRC = 8'h01;

    // Version 1.0.0
    localparam logic [31:0] VERSION_WORD = 32'h0001_0000;

    // Divisor 1085, 115200 baud from a 125 MHz clock
    localparam baud_div_t CONFIG_RESET_DEFAULT = 16'h043D;

    // Bus engine states
    typedef enum logic [2:0] {
        IDLE,
        WRITE_ADDR,
        WRITE_DATA,
        WRITE_RESP,
        READ_DATA
    } bus_state_t;

endpackage

`default_nettype wire

//--- source/uart_reg_block.sv
`timescale 1ns/100ps
`default_nettype none

module uart_reg_block import axi_lite_pkg::*, reg_map_pkg::*; #(
    parameter baud_div_t config_reset = CONFIG_RESET_DEFAULT
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       soft_reset,

    // AXI4-Lite slave
    input  wire logic       awvalid,
    input  wire axi_addr_t  awaddr,
    output logic            awready,
    input  wire logic       wvalid,
    input  wire axi_data_t  wdata,
    input  wire axi_strb_t  wstrb,
    output logic            wready,
    output logic            bvalid,
    input  wire logic       bready,
    output axi_resp_t       bresp,
    input  wire logic       arvalid,
    input  wire axi_addr_t  araddr,
    output logic            arready,
    output logic            rvalid,
    input  wire logic       rready,
    output axi_data_t       rdata,
    output axi_resp_t       rresp,

    // Bridge status
    input  wire logic       busy,
    input  wire err_code_t  error_code,
    input  wire count_t     tx_count,
    input  wire count_t     rx_count,
    input  wire fifo_stat_t fifo_status,

    // Bridge configuration
    output logic            reset_stats,
    output baud_div_t       baud_div,
    output timeout_t        timeout,
    output debug_mode_t     debug_mode
);

    reg_access_if acc_if ();

    axi_lite_slave u_slave (
        .clk        (clk),
        .rst        (rst),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .error_code (error_code),
        .acc        (acc_if)
    );

    reg_file #(
        .config_reset (config_reset)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .soft_reset  (soft_reset),
        .acc         (acc_if),
        .busy        (busy),
        .error_code  (error_code),
        .tx_count    (tx_count),
        .rx_count    (rx_count),
        .fifo_status (fifo_status),
        .reset_stats (reset_stats),
        .baud_div    (baud_div),
        .timeout     (timeout),
        .debug_mode  (debug_mode)
    );

endmodule

`default_nettype wire

//--- tests/reg_block_checker.sv
`timescale 1ns/100ps
`default_nettype none

module reg_block_checker import axi_lite_pkg::*, reg_map_pkg::*; (
    input  wire logic        clk, rst, soft_reset,
    input  wire logic        awvalid, awready, wvalid, wready, bvalid, bready,
    input  wire logic        arvalid, arready, rvalid, rready,
    input  wire axi_addr_t   awaddr, araddr,
    input  wire axi_data_t   wdata, rdata,
    input  wire axi_strb_t   wstrb,
    input  wire axi_resp_t   bresp, rresp,
    input  wire logic        busy, reset_stats,
    input  wire err_code_t   error_code,
    input  wire count_t      tx_count, rx_count,
    input  wire fifo_stat_t  fifo_status,
    input  wire baud_div_t   baud_div,
    input  wire timeout_t    timeout,
    input  wire debug_mode_t debug_mode,
    output int               errors
);

    // Shadow registers
    logic        ctrl_q;
    logic [15:0] cfg_q;
    logic [3:0]  dbg_q;
    logic [31:0] test_q [4];

    logic [11:0] wr_addr;
    logic [11:0] rd_addr;
    logic        wr_crc;     // Error code seen at AW transfer
    logic        open_txn;   // Address taken and response not yet finished
    logic        pulse_exp;
    axi_resp_t   bresp_exp;

    initial errors = 0;

    // Twelve words at 0x000 to 0x02C
    function automatic logic mapped(logic [11:0] a);
        return a[11:2] <= 10'd11;
    endfunction

    function automatic logic write_legal(logic [11:0] a, axi_strb_t s);
        case ({a[1:0], s})
            6'b00_0001, 6'b00_0011, 6'b00_1111, 6'b10_1100: return mapped(a);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic read_legal(logic [11:0] a);
        return mapped(a) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [31:0] expected_word(logic [11:0] a);
        if (!read_legal(a)) begin
            return 32'h0;
        end
        case (a[5:2])
            4'd0:    return {31'h0, ctrl_q};
            4'd1:    return {23'h0, error_code, busy};
            4'd2:    return {16'h0, cfg_q};
            4'd3:    return {28'h0, dbg_q};
            4'd4:    return {16'h0, tx_count};
            4'd5:    return {16'h0, rx_count};
            4'd6:    return {24'h0, fifo_status};
            4'd7:    return 32'h0001_0000;  // Version 1.0.0
            default: return test_q[a[3:2]];
        endcase
    endfunction

    task automatic apply_write(logic [11:0] a, axi_data_t d, axi_strb_t s);
        logic [31:0] word;
        word = expected_word({a[11:2], 2'b00});
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                word[8*i +: 8] = d[8*i +: 8];
            end
        end
        case (a[5:2])
            4'd0:    ctrl_q = word[0];
            4'd2:    cfg_q  = word[15:0];
            4'd3:    dbg_q  = word[3:0];
            4'd8, 4'd9, 4'd10, 4'd11: test_q[a[3:2]] = word;
            default: ;  // Read-only views ignore writes
        endcase
    endtask

    task automatic clear_soft_state();
        ctrl_q = 1'b0;
        dbg_q  = 4'h0;
        for (int i = 0; i < 4; i++) begin
            test_q[i] = 32'h0;
        end
    endtask

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            clear_soft_state();
            cfg_q     = 16'h043D;
            open_txn  = 1'b0;
            pulse_exp = 1'b0;
        end else begin
            compare("reset_stats", reset_stats, pulse_exp);
            compare("baud_div", baud_div, cfg_q);
            compare("timeout", timeout, cfg_q[15:8]);
            compare("debug_mode", debug_mode, dbg_q);
            if (bvalid) begin
                compare("bresp", bresp, bresp_exp);
            end
            if (rvalid) begin
                compare("rdata", rdata, expected_word(rd_addr));
                compare("rresp", rresp, read_legal(rd_addr) ? RESP_OKAY : RESP_SLVERR);
            end
            pulse_exp = 1'b0;

            if (open_txn && (awready || arready)) begin
                errors++;
                $display("An address channel was ready before the last response finished");
            end
            if ((awvalid && awready) || (arvalid && arready)) begin
                open_txn = 1'b1;
            end
            if (awvalid && awready) begin
                wr_addr = awaddr[11:0];
                wr_crc  = (error_code == ERR_CRC);
            end
            if (arvalid && arready) begin
                rd_addr = araddr[11:0];
            end
            if (wvalid && wready) begin
                bresp_exp = (write_legal(wr_addr, wstrb) && !wr_crc) ? RESP_OKAY : RESP_SLVERR;
                if (write_legal(wr_addr, wstrb) && !soft_reset) begin
                    pulse_exp = (wr_addr[11:2] == 10'd0) && wstrb[0] && wdata[1];
                    apply_write(wr_addr, wdata, wstrb);
                end
            end
            if (soft_reset) begin
                clear_soft_state();  // Config survives
            end
            if ((bvalid && bready) || (rvalid && rready)) begin
                open_txn = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_uart_reg_block.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_reg_block import axi_lite_pkg::*, reg_map_pkg::*; ();

    localparam int K_WR = 0;
    localparam int K_RD = 1;
    localparam int K_SR = 2;  // Soft reset pulse
    localparam int MAX_ENTRIES = 64;

    typedef struct packed {
        logic [1:0]  kind;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [3:0]  stall;  // Cycles of held-off bready or rready
        logic        crc;    // Drive ERR_CRC on error_code
        logic        busy;
        logic [15:0] tx;
        logic [15:0] rx;
        logic [7:0]  fifo;
    } entry_t;

    logic        clk, rst, soft_reset;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    axi_addr_t   awaddr, araddr;
    axi_data_t   wdata, rdata;
    axi_strb_t   wstrb;
    axi_resp_t   bresp, rresp;
    logic        busy, reset_stats;
    err_code_t   error_code;
    count_t      tx_count, rx_count;
    fifo_stat_t  fifo_status;
    baud_div_t   baud_div;
    timeout_t    timeout;
    debug_mode_t debug_mode;

    entry_t      stim [MAX_ENTRIES];
    entry_t      cur;
    int          n_entries;
    int          chk_errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] rng_state;

    uart_reg_block #(.config_reset(CONFIG_RESET_DEFAULT)) dut0 (.*);

    reg_block_checker checker0 (.*, .errors(chk_errors));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, chk_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic push_entry(input int kind, input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int stall, input logic crc,
                              input logic b, input logic [15:0] tx, input logic [15:0] rx,
                              input logic [7:0] fifo);
        stim[n_entries] = {2'(kind), addr, data, strb, 4'(stall), crc, b, tx, rx, fifo};
        n_entries++;
    endtask

    task automatic add_entry(input int kind, input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall, input logic crc);
        push_entry(kind, addr, data, strb, stall, crc, 1'b0, 16'h0, 16'h0, 8'h0);
    endtask

    // Hold off the response channel and then take the response
    task automatic take_response(input int stall, input logic is_write);
        repeat (stall) begin
            @(posedge clk);
            #1;
        end
        bready = is_write;
        rready = !is_write;
        do @(posedge clk); while (!(is_write ? bvalid : rvalid));
        #1;
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic write_access(input entry_t e);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = {20'h0, e.addr};
        wdata   = e.data;
        wstrb   = e.strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;  // Held until wready after the AW transfer
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            aw_done = aw_done || awready;
            w_done  = w_done || wready;
            #1;
            awvalid = !aw_done;
            wvalid  = !w_done;
        end
        take_response(e.stall, 1'b1);
    endtask

    task automatic read_access(input entry_t e);
        araddr  = {20'h0, e.addr};
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        #1;
        arvalid = 1'b0;
        take_response(e.stall, 1'b0);
    endtask

    task automatic pulse_soft_reset();
        soft_reset = 1'b1;
        @(posedge clk);
        #1;
        soft_reset = 1'b0;
    endtask

    initial begin
        n_entries = 0;
        cycles    = 0;
        rng_state = 32'h4009_4b1d;

        // Reset values
        add_entry(K_RD, 12'h008, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h000, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h00C, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h020, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h01C, 32'h0, 4'h0, 0, 1'b0);
        // Random full words with some stalled responses
        add_entry(K_WR, 12'h020, next_random(), 4'hF, 0, 1'b0);
        add_entry(K_WR, 12'h02C, next_random(), 4'hF, 2, 1'b0);
        add_entry(K_WR, 12'h000, next_random(), 4'hF, 0, 1'b0);
        add_entry(K_WR, 12'h008, next_random(), 4'hF, 0, 1'b0);
        add_entry(K_WR, 12'h00C, next_random(), 4'hF, 3, 1'b0);
        add_entry(K_RD, 12'h020, 32'h0, 4'h0, 1, 1'b0);
        add_entry(K_RD, 12'h02C, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h000, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h008, 32'h0, 4'h0, 4, 1'b0);
        add_entry(K_RD, 12'h00C, 32'h0, 4'h0, 0, 1'b0);
        // Partial strobes
        add_entry(K_WR, 12'h024, 32'h1122_33AA, 4'b0001, 0, 1'b0);
        add_entry(K_WR, 12'h028, 32'h5566_BBCC, 4'b0011, 0, 1'b0);
        add_entry(K_WR, 12'h02A, 32'hDDEE_7788, 4'b1100, 0, 1'b0);
        add_entry(K_RD, 12'h024, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h028, 32'h0, 4'h0, 0, 1'b0);
        // Illegal accesses
        add_entry(K_WR, 12'h02C, 32'hFFFF_FFFF, 4'b0110, 0, 1'b0);
        add_entry(K_WR, 12'h021, 32'hFFFF_FFFF, 4'b0001, 0, 1'b0);
        add_entry(K_WR, 12'h030, 32'hFFFF_FFFF, 4'b1111, 2, 1'b0);
        add_entry(K_RD, 12'h022, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h02C, 32'h0, 4'h0, 2, 1'b0);
        add_entry(K_RD, 12'h020, 32'h0, 4'h0, 0, 1'b0);
        // CRC error response and statistics reset
        add_entry(K_WR, 12'h024, 32'hCAFE_0001, 4'hF, 0, 1'b1);
        add_entry(K_RD, 12'h024, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_WR, 12'h000, 32'h0000_0003, 4'b0001, 0, 1'b0);
        add_entry(K_RD, 12'h000, 32'h0, 4'h0, 0, 1'b0);
        // Soft reset and status views
        add_entry(K_SR, 12'h000, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h000, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h008, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h00C, 32'h0, 4'h0, 0, 1'b0);
        add_entry(K_RD, 12'h020, 32'h0, 4'h0, 0, 1'b0);
        push_entry(K_RD, 12'h004, 32'h0, 4'h0, 0, 1'b1, 1'b1, 16'h0, 16'h0, 8'h0);
        push_entry(K_RD, 12'h010, 32'h0, 4'h0, 0, 1'b0, 1'b0, 16'h1234, 16'h0, 8'h0);
        push_entry(K_RD, 12'h014, 32'h0, 4'h0, 3, 1'b0, 1'b0, 16'h0, 16'hBEEF, 8'h0);
        push_entry(K_RD, 12'h018, 32'h0, 4'h0, 0, 1'b0, 1'b0, 16'h0, 16'h0, 8'hA5);
        cycle_limit = 40 * n_entries + 100;

        rst         = 1'b1;
        soft_reset  = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        busy        = 1'b0;
        error_code  = '0;
        tx_count    = '0;
        rx_count    = '0;
        fifo_status = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            cur         = stim[i];
            error_code  = cur.crc ? ERR_CRC : 8'h00;
            busy        = cur.busy;
            tx_count    = cur.tx;
            rx_count    = cur.rx;
            fifo_status = cur.fifo;
            case (cur.kind)
                K_WR:    write_access(cur);
                K_RD:    read_access(cur);
                default: pulse_soft_reset();
            endcase
            @(posedge clk);  // Idle cycle between entries
            #1;
        end

        repeat (2) @(posedge clk);
        #1;
        $display("Checker errors: %0d", chk_errors);
        if (chk_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
